// ==== rtl/lsu_pkg.sv ====
package lsu_pkg;

    localparam int DATA_W = 32;

    // load format
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // store format, immediate split around the register fields
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        i_fmt_t i;
        s_fmt_t s;
    } instr_t;

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // same as funct3[1:0]
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_t;

    localparam logic [4:0] REG_INSTR  = 5'h00;
    localparam logic [4:0] REG_BASE   = 5'h04;
    localparam logic [4:0] REG_WDATA  = 5'h08;
    localparam logic [4:0] REG_RESULT = 5'h0C;
    localparam logic [4:0] REG_STATUS = 5'h10;

endpackage

// ==== rtl/lsu_decoder.sv ====
`timescale 1ns/1ps

module lsu_decoder #(
    parameter int ADDR_W = 10
) (
    input  logic                         launch,
    input  lsu_pkg::instr_t              instr,
    input  logic [lsu_pkg::DATA_W-1:0]   base,
    output logic [ADDR_W-1:0]            byte_address,
    output logic                         write_enable,
    output lsu_pkg::mem_size_t           mem_size,
    output logic                         mem_sign,
    output logic                         load_ok,
    output logic                         misaligned,
    output logic                         illegal
);

    logic                       is_load;
    logic                       is_store;
    logic [2:0]                 funct3;
    logic [11:0]                imm;
    logic [lsu_pkg::DATA_W-1:0] eff_addr;
    logic                       funct3_ok;

    assign is_load  = (instr.i.opcode == lsu_pkg::OPC_LOAD);
    assign is_store = (instr.s.opcode == lsu_pkg::OPC_STORE);

    // funct3 sits in the same bits in both views
    assign funct3 = instr.i.funct3;
    assign imm    = is_store ? {instr.s.imm_hi, instr.s.imm_lo} : instr.i.imm;

    assign eff_addr     = base + {{(lsu_pkg::DATA_W - 12){imm[11]}}, imm};
    assign byte_address = eff_addr[ADDR_W-1:0];

    always_comb begin
        funct3_ok = 1'b0;
        if (is_load) begin
            case (funct3)
                lsu_pkg::F3_LB,
                lsu_pkg::F3_LH,
                lsu_pkg::F3_LW,
                lsu_pkg::F3_LBU,
                lsu_pkg::F3_LHU: funct3_ok = 1'b1;
                default:         funct3_ok = 1'b0;
            endcase
        end else if (is_store) begin
            case (funct3)
                lsu_pkg::F3_SB,
                lsu_pkg::F3_SH,
                lsu_pkg::F3_SW: funct3_ok = 1'b1;
                default:        funct3_ok = 1'b0;
            endcase
        end
    end

    assign illegal  = !funct3_ok;
    assign mem_size = lsu_pkg::mem_size_t'(funct3[1:0]);
    // bit 2 marks the unsigned loads
    assign mem_sign = !funct3[2];

    always_comb begin
        misaligned = 1'b0;
        if (!illegal) begin
            case (mem_size)
                lsu_pkg::SIZE_HALF: misaligned = byte_address[0];
                lsu_pkg::SIZE_WORD: misaligned = (byte_address[1:0] != 2'b00);
                default:            misaligned = 1'b0;
            endcase
        end
    end

    // faulty accesses never reach memory or result
    assign write_enable = launch && is_store && !illegal && !misaligned;
    assign load_ok      = is_load && !illegal && !misaligned;

endmodule

// ==== rtl/data_memory.sv ====
`timescale 1ns/1ps

module data_memory #(
    parameter int ADDR_W = 10
) (
    input  logic                       clk,
    input  logic [ADDR_W-1:0]          byte_address,
    input  logic                       write_enable,
    input  logic [lsu_pkg::DATA_W-1:0] write_data,
    input  lsu_pkg::mem_size_t         mem_size,
    input  logic                       mem_sign,
    output logic [lsu_pkg::DATA_W-1:0] read_data
);

    localparam int DEPTH = 2 ** (ADDR_W - 2);

    logic [lsu_pkg::DATA_W-1:0] ram [DEPTH];
    logic [ADDR_W-3:0]          word_address;
    logic [1:0]                 byte_offset;
    logic [3:0]                 lane_mask;
    logic [lsu_pkg::DATA_W-1:0] lane_data;
    logic [lsu_pkg::DATA_W-1:0] word;
    logic [7:0]                 byte_lane;
    logic [15:0]                half_lane;

    assign word_address = byte_address[ADDR_W-1:2];
    assign byte_offset  = byte_address[1:0];

    // replicate the store data so every lane sees it, mask picks the lanes
    always_comb begin
        case (mem_size)
            lsu_pkg::SIZE_BYTE: begin
                lane_mask = 4'b0001 << byte_offset;
                lane_data = {4{write_data[7:0]}};
            end
            lsu_pkg::SIZE_HALF: begin
                lane_mask = byte_offset[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{write_data[15:0]}};
            end
            lsu_pkg::SIZE_WORD: begin
                lane_mask = 4'b1111;
                lane_data = write_data;
            end
            default: begin
                lane_mask = 4'b0000;
                lane_data = write_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_mask[i]) begin
                    ram[word_address][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
        end
    end

    assign word      = ram[word_address];
    assign byte_lane = word[8*byte_offset +: 8];
    assign half_lane = word[16*byte_offset[1] +: 16];

    always_comb begin
        case (mem_size)
            lsu_pkg::SIZE_BYTE: begin
                read_data = mem_sign ? {{24{byte_lane[7]}}, byte_lane} : {24'b0, byte_lane};
            end
            lsu_pkg::SIZE_HALF: begin
                read_data = mem_sign ? {{16{half_lane[15]}}, half_lane} : {16'b0, half_lane};
            end
            default: begin
                read_data = word;
            end
        endcase
    end

endmodule

// ==== rtl/lsu_apb_regs.sv ====
`timescale 1ns/1ps

module lsu_apb_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [4:0]                 paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [lsu_pkg::DATA_W-1:0] pwdata,
    output logic [lsu_pkg::DATA_W-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       launch,
    output lsu_pkg::instr_t            instr,
    output logic [lsu_pkg::DATA_W-1:0] base,
    output logic [lsu_pkg::DATA_W-1:0] wdata,
    input  logic                       load_ok,
    input  logic                       misaligned,
    input  logic                       illegal,
    input  logic [lsu_pkg::DATA_W-1:0] read_data
);

    logic                       access;
    logic                       instr_wr;
    logic                       map_err;
    logic [lsu_pkg::DATA_W-1:0] result;
    logic [1:0]                 status;

    assign access   = psel && penable;
    assign instr_wr = access && pwrite && (paddr == lsu_pkg::REG_INSTR);

    // instruction write holds pready low for its first access cycle
    assign pready  = access && (!instr_wr || launch);
    assign pslverr = pready && (instr_wr ? (misaligned || illegal) : map_err);

    always_comb begin
        prdata  = '0;
        map_err = 1'b0;
        case (paddr)
            lsu_pkg::REG_INSTR: begin
                map_err = !pwrite;
            end
            lsu_pkg::REG_BASE: begin
                prdata = base;
            end
            lsu_pkg::REG_WDATA: begin
                prdata = wdata;
            end
            lsu_pkg::REG_RESULT: begin
                prdata  = result;
                map_err = pwrite;
            end
            lsu_pkg::REG_STATUS: begin
                prdata  = {{(lsu_pkg::DATA_W - 2){1'b0}}, status};
                map_err = pwrite;
            end
            default: begin
                map_err = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            launch <= 1'b0;
            base   <= '0;
            wdata  <= '0;
            result <= '0;
            status <= '0;
        end else begin
            // one cycle pulse, runs the access in the second access cycle
            launch <= instr_wr && !launch;
            if (access && pwrite && (paddr == lsu_pkg::REG_BASE)) begin
                base <= pwdata;
            end
            if (access && pwrite && (paddr == lsu_pkg::REG_WDATA)) begin
                wdata <= pwdata;
            end
            if (launch) begin
                status <= {illegal, misaligned};
                if (load_ok) begin
                    result <= read_data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_wr && !launch) begin
            instr <= pwdata;
        end
    end

endmodule

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top #(
    parameter int ADDR_W = 10
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic                       launch;
    lsu_pkg::instr_t            instr;
    logic [lsu_pkg::DATA_W-1:0] base;
    logic [lsu_pkg::DATA_W-1:0] wdata;
    logic [lsu_pkg::DATA_W-1:0] read_data;
    logic [ADDR_W-1:0]          byte_address;
    logic                       write_enable;
    lsu_pkg::mem_size_t         mem_size;
    logic                       mem_sign;
    logic                       load_ok;
    logic                       misaligned;
    logic                       illegal;

    lsu_apb_regs i_regs (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .launch     (launch),
        .instr      (instr),
        .base       (base),
        .wdata      (wdata),
        .load_ok    (load_ok),
        .misaligned (misaligned),
        .illegal    (illegal),
        .read_data  (read_data)
    );

    lsu_decoder #(
        .ADDR_W (ADDR_W)
    ) i_decoder (
        .launch       (launch),
        .instr        (instr),
        .base         (base),
        .byte_address (byte_address),
        .write_enable (write_enable),
        .mem_size     (mem_size),
        .mem_sign     (mem_sign),
        .load_ok      (load_ok),
        .misaligned   (misaligned),
        .illegal      (illegal)
    );

    data_memory #(
        .ADDR_W (ADDR_W)
    ) i_memory (
        .clk          (clk),
        .byte_address (byte_address),
        .write_enable (write_enable),
        .write_data   (wdata),
        .mem_size     (mem_size),
        .mem_sign     (mem_sign),
        .read_data    (read_data)
    );

endmodule

// ==== include/lsu_tb_model.svh ====
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

// byte image of the data memory, unknown until written
logic [7:0] model_mem [2**ADDR_W];

function automatic logic [ADDR_W-1:0] model_address(lsu_pkg::instr_t ins, logic [31:0] rs1);
    logic [11:0] imm;
    logic [31:0] sum;
    imm = (ins.i.opcode == lsu_pkg::OPC_STORE) ? {ins.s.imm_hi, ins.s.imm_lo} : ins.i.imm;
    sum = rs1 + {{20{imm[11]}}, imm};
    return sum[ADDR_W-1:0];
endfunction

function automatic logic model_illegal(lsu_pkg::instr_t ins);
    if (ins.i.opcode == lsu_pkg::OPC_LOAD) begin
        return !(ins.i.funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
    end
    if (ins.s.opcode == lsu_pkg::OPC_STORE) begin
        return !(ins.s.funct3 inside {3'b000, 3'b001, 3'b010});
    end
    return 1'b1;
endfunction

function automatic logic model_misaligned(lsu_pkg::instr_t ins, logic [31:0] rs1);
    logic [ADDR_W-1:0] addr;
    addr = model_address(ins, rs1);
    if (model_illegal(ins)) begin
        return 1'b0;
    end
    // access size is funct3[1:0]
    if (ins.i.funct3[1:0] == 2'b01) begin
        return addr[0];
    end
    return (ins.i.funct3[1:0] == 2'b10) && (addr[1:0] != 2'b00);
endfunction

function automatic logic [31:0] model_load(logic [ADDR_W-1:0] addr, logic [2:0] funct3);
    logic [7:0]  b;
    logic [15:0] h;
    b = model_mem[addr];
    h = {model_mem[addr + 1], model_mem[addr]};
    case (funct3)
        3'b000:  return {{24{b[7]}}, b};
        3'b100:  return {24'b0, b};
        3'b001:  return {{16{h[15]}}, h};
        3'b101:  return {16'b0, h};
        default: return {model_mem[addr + 3], model_mem[addr + 2], h};
    endcase
endfunction

task automatic model_store(input logic [ADDR_W-1:0] addr, input logic [2:0] funct3,
                           input logic [31:0] data);
    for (int i = 0; i < (1 << funct3[1:0]); i++) begin
        model_mem[addr + i] = data[8*i +: 8];
    end
endtask

`endif

// ==== testbench/tb_lsu_top.sv ====
`timescale 1ns/1ps

module tb_lsu_top;

    localparam int ADDR_W   = 10;
    localparam int MAX_WAIT = 16;

    logic              clk;
    logic              rst;
    logic [4:0]        paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;

    int                seed = 32'h0901b76c;
    int                checks = 0;
    int                errors = 0;
    int                tests = 0;
    int                test_checks = 0;
    int                test_errors = 0;
    logic [31:0]       model_result;
    // word addresses that hold known data
    logic [ADDR_W-1:0] stored [$];

    `include "lsu_tb_model.svh"

    lsu_top #(
        .ADDR_W (ADDR_W)
    ) i_lsu_top (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s: %0d checks, %0d errors", tests, name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // one APB transfer, outputs sampled mid cycle
    task automatic apb_access(input logic wr, input logic [4:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err, output int cycles);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        cycles  = 1;
        @(negedge clk);
        while (!pready && cycles < MAX_WAIT) begin
            cycles++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        assert (pready)
        else begin
            errors++;
            $display("no pready within %0d cycles at offset %h", MAX_WAIT, addr);
        end
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic single_access(input logic wr, input logic [4:0] addr,
                                 input logic [31:0] data, input logic exp_err,
                                 output logic [31:0] rdata);
        logic err;
        int   cycles;
        apb_access(wr, addr, data, rdata, err, cycles);
        check_value("access cycles", 1, cycles);
        check_value("pslverr", exp_err, err);
    endtask

    // random base and immediate that together reach target
    task automatic run_access(input logic [6:0] opc, input logic [2:0] f3,
                              input logic [ADDR_W-1:0] target, input logic [31:0] data);
        logic [11:0]     imm;
        logic [4:0]      other;
        lsu_pkg::instr_t ins;
        logic [31:0]     rs1;
        logic [31:0]     rdata;
        logic            err;
        logic            bad;
        int              cycles;
        imm   = $random(seed);
        other = $random(seed);
        if (opc == lsu_pkg::OPC_STORE) begin
            ins = {imm[11:5], other, other, f3, imm[4:0], opc};
        end else begin
            ins = {imm, other, f3, other, opc};
        end
        rs1 = $random(seed);
        rs1[ADDR_W-1:0] = target;
        rs1 = rs1 - {{20{imm[11]}}, imm};
        single_access(1'b1, lsu_pkg::REG_BASE, rs1, 1'b0, rdata);
        single_access(1'b1, lsu_pkg::REG_WDATA, data, 1'b0, rdata);
        apb_access(1'b1, lsu_pkg::REG_INSTR, ins, rdata, err, cycles);
        bad = model_illegal(ins) || model_misaligned(ins, rs1);
        check_value("instr access cycles", 2, cycles);
        check_value("pslverr", bad, err);
        if (!bad && ins.s.opcode == lsu_pkg::OPC_STORE) begin
            model_store(model_address(ins, rs1), ins.s.funct3, data);
        end
        if (!bad && ins.i.opcode == lsu_pkg::OPC_LOAD) begin
            model_result = model_load(model_address(ins, rs1), ins.i.funct3);
        end
        single_access(1'b0, lsu_pkg::REG_STATUS, '0, 1'b0, rdata);
        check_value("status", {30'b0, model_illegal(ins), model_misaligned(ins, rs1)}, rdata);
        single_access(1'b0, lsu_pkg::REG_RESULT, '0, 1'b0, rdata);
        check_value("result", model_result, rdata);
    endtask

    initial begin
        logic [31:0]       rdata;
        logic [31:0]       data;
        logic [ADDR_W-1:0] target;
        logic [6:0]        opc;
        logic [2:0]        f3;
        logic [4:0]        offset;
        clk          = 1'b0;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        model_result = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        single_access(1'b0, lsu_pkg::REG_RESULT, '0, 1'b0, rdata);
        check_value("result", 32'h0, rdata);
        single_access(1'b0, lsu_pkg::REG_STATUS, '0, 1'b0, rdata);
        check_value("status", 32'h0, rdata);
        repeat (8) begin
            data = $random(seed);
            single_access(1'b1, lsu_pkg::REG_BASE, data, 1'b0, rdata);
            single_access(1'b0, lsu_pkg::REG_BASE, '0, 1'b0, rdata);
            check_value("base", data, rdata);
            data = $random(seed);
            single_access(1'b1, lsu_pkg::REG_WDATA, data, 1'b0, rdata);
            single_access(1'b0, lsu_pkg::REG_WDATA, '0, 1'b0, rdata);
            check_value("wdata", data, rdata);
        end
        finish_test("register access");

        repeat (200) begin
            target = $random(seed);
            target[1:0] = 2'b00;
            run_access(lsu_pkg::OPC_STORE, lsu_pkg::F3_SW, target, $random(seed));
            run_access(lsu_pkg::OPC_LOAD, lsu_pkg::F3_LW, target, '0);
            stored.push_back(target);
        end
        finish_test("word stores and loads");

        repeat (100) begin
            target = stored[$unsigned($random(seed)) % stored.size()];
            if ($random(seed) & 1) begin
                target[1:0] = $random(seed);
                run_access(lsu_pkg::OPC_STORE, lsu_pkg::F3_SB, target, $random(seed));
                run_access(lsu_pkg::OPC_LOAD, lsu_pkg::F3_LB, target, '0);
                run_access(lsu_pkg::OPC_LOAD, lsu_pkg::F3_LBU, target, '0);
            end else begin
                target[1] = $random(seed);
                run_access(lsu_pkg::OPC_STORE, lsu_pkg::F3_SH, target, $random(seed));
                run_access(lsu_pkg::OPC_LOAD, lsu_pkg::F3_LH, target, '0);
                run_access(lsu_pkg::OPC_LOAD, lsu_pkg::F3_LHU, target, '0);
            end
            // other lanes of the word
            target[1:0] = 2'b00;
            run_access(lsu_pkg::OPC_LOAD, lsu_pkg::F3_LW, target, '0);
        end
        finish_test("sub-word access");

        repeat (60) begin
            target = stored[$unsigned($random(seed)) % stored.size()];
            f3 = ($random(seed) & 1) ? lsu_pkg::F3_LH : lsu_pkg::F3_LW;
            if (f3 == lsu_pkg::F3_LH) begin
                target[1] = $random(seed);
                target[0] = 1'b1;
            end else begin
                target[1:0] = $random(seed);
                if (target[1:0] == 2'b00) begin
                    target[0] = 1'b1;
                end
            end
            opc = ($random(seed) & 1) ? lsu_pkg::OPC_STORE : lsu_pkg::OPC_LOAD;
            if (opc == lsu_pkg::OPC_LOAD && f3 == lsu_pkg::F3_LH && ($random(seed) & 1)) begin
                f3 = lsu_pkg::F3_LHU;
            end
            run_access(opc, f3, target, $random(seed));
            target[1:0] = 2'b00;
            run_access(lsu_pkg::OPC_LOAD, lsu_pkg::F3_LW, target, '0);
        end
        finish_test("misaligned access");

        repeat (60) begin
            target = stored[$unsigned($random(seed)) % stored.size()];
            f3 = $random(seed);
            if ($random(seed) & 1) begin
                opc = $random(seed);
                // steer clear of load and store
                if (opc == lsu_pkg::OPC_LOAD || opc == lsu_pkg::OPC_STORE) begin
                    opc[4] = ~opc[4];
                end
            end else begin
                opc = ($random(seed) & 1) ? lsu_pkg::OPC_STORE : lsu_pkg::OPC_LOAD;
                f3[1] = 1'b1;
                if (f3 == 3'b010) begin
                    f3 = 3'b110;
                end
            end
            run_access(opc, f3, target, $random(seed));
            run_access(lsu_pkg::OPC_LOAD, lsu_pkg::F3_LW, target, '0);
        end
        repeat (10) begin
            offset = $random(seed);
            if (offset inside {5'h00, 5'h04, 5'h08, 5'h0C, 5'h10}) begin
                offset[0] = 1'b1;
            end
            single_access(1'b0, offset, '0, 1'b1, rdata);
        end
        single_access(1'b1, lsu_pkg::REG_RESULT, $random(seed), 1'b1, rdata);
        single_access(1'b1, lsu_pkg::REG_STATUS, $random(seed), 1'b1, rdata);
        single_access(1'b0, lsu_pkg::REG_RESULT, '0, 1'b0, rdata);
        check_value("result", model_result, rdata);
        // last access was a legal word load
        single_access(1'b0, lsu_pkg::REG_STATUS, '0, 1'b0, rdata);
        check_value("status", 32'h0, rdata);
        finish_test("illegal instructions");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
rtl/lsu_pkg.sv
rtl/lsu_decoder.sv
rtl/data_memory.sv
rtl/lsu_apb_regs.sv
rtl/lsu_top.sv
testbench/tb_lsu_top.sv

// ==== Bender.yml ====
package:
  name: lsu_apb

sources:
  - rtl/lsu_pkg.sv
  - rtl/lsu_decoder.sv
  - rtl/data_memory.sv
  - rtl/lsu_apb_regs.sv
  - rtl/lsu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_lsu_top.sv
